/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // core-side memory operations
  typedef enum logic [2:0] {
    LB  = 3'd0,
    LBU = 3'd1,
    LH  = 3'd2,
    LHU = 3'd3,
    LW  = 3'd4,
    SB  = 3'd5,
    SH  = 3'd6,
    SW  = 3'd7
  } lsu_op_e;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE_RD,
    ISSUE_WR,
    WAIT_R,
    WAIT_B,
    RESP
  } lsu_state_e;

  function automatic logic is_store(input lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(input lsu_op_e op);
    case (op)
      LB, LBU, SB: return 2'd0;
      LH, LHU, SH: return 2'd1;
      default:     return 2'd2;
    endcase
  endfunction

endpackage

`default_nettype wire

/* verilog/axil_pkg.sv */
`default_nettype none

package axil_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // AXI response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

endpackage

`default_nettype wire

/* verilog/load_extract.sv */
`timescale 1ns/1ns
`default_nettype none

module load_extract (
  input  lsu_pkg::lsu_op_e              op,
  input  logic [1:0]                    offset,
  input  logic [axil_pkg::DATA_W-1:0]   rdata,
  output logic [axil_pkg::DATA_W-1:0]   value
);

  logic [axil_pkg::DATA_W-1:0] shifted;

  // bring the addressed byte down to lane 0
  always_comb begin
    case (offset)
      2'b00:   shifted = rdata;
      2'b01:   shifted = {8'b0, rdata[31:8]};
      2'b10:   shifted = {16'b0, rdata[31:16]};
      default: shifted = {24'b0, rdata[31:24]};
    endcase
  end

  always_comb begin
    case (op)
      lsu_pkg::LB:  value = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::LBU: value = {24'b0, shifted[7:0]};
      lsu_pkg::LH:  value = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::LHU: value = {16'b0, shifted[15:0]};
      // word loads pass the whole lane
      default:      value = shifted;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/store_align.sv */
`timescale 1ns/1ns
`default_nettype none

module store_align (
  input  lsu_pkg::lsu_op_e              op,
  input  logic [axil_pkg::ADDR_W-1:0]   addr,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  output logic [axil_pkg::DATA_W-1:0]   lane_data,
  output logic [axil_pkg::STRB_W-1:0]   strb,
  output logic                          misaligned
);

  logic [1:0]                  offset;
  logic [1:0]                  size;
  logic [axil_pkg::STRB_W-1:0] base_mask;

  assign offset = addr[1:0];
  assign size   = lsu_pkg::op_size(op);

  // move store data up to the addressed byte lane
  always_comb begin
    case (offset)
      2'b00:   lane_data = wdata;
      2'b01:   lane_data = {wdata[23:0], 8'b0};
      2'b10:   lane_data = {wdata[15:0], 16'b0};
      default: lane_data = {wdata[7:0], 24'b0};
    endcase
  end

  always_comb begin
    case (size)
      2'd0:    base_mask = 4'b0001;
      2'd1:    base_mask = 4'b0011;
      default: base_mask = 4'b1111;
    endcase
  end

  // loads never write, so their strobe stays empty
  assign strb = lsu_pkg::is_store(op) ? (base_mask << offset) : '0;

  // halfwords need an even offset, words a zero offset
  always_comb begin
    case (size)
      2'd1:    misaligned = offset[0];
      2'd2:    misaligned = |offset;
      default: misaligned = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/lsu_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_fsm (
  input  logic                          clk,
  input  logic                          rstn,
  // core request
  input  logic                          req_valid,
  input  lsu_pkg::lsu_op_e              req_op,
  input  logic [axil_pkg::ADDR_W-1:0]   req_addr,
  input  logic [axil_pkg::DATA_W-1:0]   req_wdata,
  output logic                          req_ready,
  // core response
  output logic                          rsp_valid,
  output logic [axil_pkg::DATA_W-1:0]   rsp_rdata,
  output logic                          rsp_err,
  input  logic                          rsp_ready,
  // data path helpers
  input  logic                          misaligned,
  input  logic [axil_pkg::DATA_W-1:0]   lane_data,
  input  logic [axil_pkg::STRB_W-1:0]   strb,
  input  logic [axil_pkg::DATA_W-1:0]   load_value,
  output logic [1:0]                    offset,
  output lsu_pkg::lsu_op_e              op_q,
  // AXI4-Lite master
  output logic [axil_pkg::ADDR_W-1:0]   araddr,
  output logic                          arvalid,
  input  logic                          arready,
  input  logic [axil_pkg::DATA_W-1:0]   rdata,
  input  axil_pkg::resp_e               rresp,
  input  logic                          rvalid,
  output logic                          rready,
  output logic [axil_pkg::ADDR_W-1:0]   awaddr,
  output logic                          awvalid,
  input  logic                          awready,
  output logic [axil_pkg::DATA_W-1:0]   wdata,
  output logic [axil_pkg::STRB_W-1:0]   wstrb,
  output logic                          wvalid,
  input  logic                          wready,
  input  axil_pkg::resp_e               bresp,
  input  logic                          bvalid,
  output logic                          bready
);

  lsu_pkg::lsu_state_e         state;
  logic [axil_pkg::ADDR_W-1:0] addr_q;
  logic [axil_pkg::DATA_W-1:0] wdata_q;
  logic [axil_pkg::STRB_W-1:0] strb_q;
  logic                        aw_done;
  logic                        w_done;
  logic                        aw_fin;
  logic                        w_fin;

  assign req_ready = (state == lsu_pkg::IDLE);
  assign rsp_valid = (state == lsu_pkg::RESP);
  assign arvalid   = (state == lsu_pkg::ISSUE_RD);
  assign rready    = (state == lsu_pkg::WAIT_R);
  assign bready    = (state == lsu_pkg::WAIT_B);

  // AW and W go up together, each drops on its own handshake
  assign awvalid = (state == lsu_pkg::ISSUE_WR) && !aw_done;
  assign wvalid  = (state == lsu_pkg::ISSUE_WR) && !w_done;
  assign aw_fin  = aw_done || (awvalid && awready);
  assign w_fin   = w_done || (wvalid && wready);

  assign araddr = addr_q;
  assign awaddr = addr_q;
  assign wdata  = wdata_q;
  assign wstrb  = strb_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= lsu_pkg::IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::IDLE: begin
          if (req_valid) begin
            // misaligned requests skip the bus entirely
            if (misaligned) state <= lsu_pkg::RESP;
            else if (lsu_pkg::is_store(req_op)) state <= lsu_pkg::ISSUE_WR;
            else state <= lsu_pkg::ISSUE_RD;
          end
        end
        lsu_pkg::ISSUE_RD: if (arready) state <= lsu_pkg::WAIT_R;
        lsu_pkg::WAIT_R:   if (rvalid) state <= lsu_pkg::RESP;
        lsu_pkg::ISSUE_WR: begin
          if (aw_fin && w_fin) begin
            state   <= lsu_pkg::WAIT_B;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end else begin
            aw_done <= aw_fin;
            w_done  <= w_fin;
          end
        end
        lsu_pkg::WAIT_B:   if (bvalid) state <= lsu_pkg::RESP;
        lsu_pkg::RESP:     if (rsp_ready) state <= lsu_pkg::IDLE;
        default:           state <= lsu_pkg::IDLE;
      endcase
    end
  end

  // request capture and response registers
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q  <= {req_addr[axil_pkg::ADDR_W-1:2], 2'b00};
      offset  <= req_addr[1:0];
      op_q    <= req_op;
      wdata_q <= lane_data;
      strb_q  <= strb;
      rsp_err   <= misaligned;
      rsp_rdata <= '0;
    end
    if (rvalid && rready) begin
      rsp_rdata <= load_value;
      rsp_err   <= (rresp != axil_pkg::OKAY);
    end
    if (bvalid && bready) begin
      rsp_rdata <= '0;
      rsp_err   <= (bresp != axil_pkg::OKAY);
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err));

  a_ar_aw_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(arvalid && awvalid));

  // the core keeps a waiting request in place
  a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    req_valid && !req_ready |=> req_valid && $stable(req_op) && $stable(req_addr)
      && $stable(req_wdata));

endmodule

`default_nettype wire

/* verilog/wait_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module wait_timer #(
  parameter int CYCLES = 2
) (
  input  logic clk,
  input  logic rstn,
  input  logic start,
  output logic done
);

  // CYCLES must be at least 1
  localparam int CNT_W = $clog2(CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (start) begin
      cnt <= CNT_W'(CYCLES);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // pulse in the last counting cycle, the count hits zero on the next edge
  assign done = (cnt == CNT_W'(1));

  a_no_restart: assert property (@(posedge clk) disable iff (!rstn)
    (cnt != '0) |-> !start);

endmodule

`default_nettype wire

/* verilog/axil_sram.sv */
`timescale 1ns/1ns
`default_nettype none

module axil_sram #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [axil_pkg::ADDR_W-1:0]   araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [axil_pkg::DATA_W-1:0]   rdata,
  output axil_pkg::resp_e               rresp,
  output logic                          rvalid,
  input  logic                          rready,
  input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axil_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_pkg::STRB_W-1:0]   wstrb,
  input  logic                          wvalid,
  output logic                          wready,
  output axil_pkg::resp_e               bresp,
  output logic                          bvalid,
  input  logic                          bready
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [axil_pkg::DATA_W-1:0] mem [MEM_WORDS];
  logic [axil_pkg::ADDR_W-1:0] addr_q;
  logic [axil_pkg::DATA_W-1:0] wdata_q;
  logic [axil_pkg::STRB_W-1:0] wstrb_q;
  logic [axil_pkg::ADDR_W-3:0] word_idx;
  logic                        in_range;
  logic                        rd_busy;
  logic                        wr_busy;
  logic                        aw_got;
  logic                        w_got;
  logic                        wr_open;
  logic                        idle;
  logic                        ar_hs;
  logic                        aw_hs;
  logic                        w_hs;
  logic                        wr_start;
  logic                        timer_done;

  // one access at a time, a presented read wins over a fresh write
  assign wr_open = aw_got || w_got;
  assign idle    = !rd_busy && !wr_busy;
  assign arready = idle && !wr_open;
  assign awready = idle && !aw_got && (wr_open || !arvalid);
  assign wready  = idle && !w_got && (wr_open || !arvalid);

  assign ar_hs    = arvalid && arready;
  assign aw_hs    = awvalid && awready;
  assign w_hs     = wvalid && wready;
  assign wr_start = (aw_got || aw_hs) && (w_got || w_hs);

  assign word_idx = addr_q[axil_pkg::ADDR_W-1:2];
  assign in_range = (word_idx < MEM_WORDS);

  // latency counts from the last channel acceptance
  wait_timer #(
    .CYCLES (MEM_LATENCY)
  ) u_timer (
    .clk   (clk),
    .rstn  (rstn),
    .start (ar_hs || wr_start),
    .done  (timer_done)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_busy <= 1'b0;
      wr_busy <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (ar_hs) rd_busy <= 1'b1;
      if (wr_start) begin
        wr_busy <= 1'b1;
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
      end else begin
        if (aw_hs) aw_got <= 1'b1;
        if (w_hs) w_got <= 1'b1;
      end
      if (timer_done && rd_busy) rvalid <= 1'b1;
      if (timer_done && wr_busy) bvalid <= 1'b1;
      if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_busy <= 1'b0;
      end
      if (bvalid && bready) begin
        bvalid  <= 1'b0;
        wr_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) addr_q <= araddr;
    else if (aw_hs) addr_q <= awaddr;
    if (w_hs) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (timer_done && rd_busy) begin
      rdata <= in_range ? mem[word_idx[IDX_W-1:0]] : '0;
      rresp <= in_range ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
    if (timer_done && wr_busy) begin
      // out-of-range writes leave the array alone
      if (in_range) begin
        for (int i = 0; i < axil_pkg::STRB_W; i++) begin
          if (wstrb_q[i]) mem[word_idx[IDX_W-1:0]][8*i +: 8] <= wdata_q[8*i +: 8];
        end
      end
      bresp <= in_range ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
  end

  a_r_b_excl: assert property (@(posedge clk) disable iff (!rstn)
    !(rvalid && bvalid));

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          req_valid,
  input  lsu_pkg::lsu_op_e              req_op,
  input  logic [axil_pkg::ADDR_W-1:0]   req_addr,
  input  logic [axil_pkg::DATA_W-1:0]   req_wdata,
  output logic                          req_ready,
  output logic                          rsp_valid,
  output logic [axil_pkg::DATA_W-1:0]   rsp_rdata,
  output logic                          rsp_err,
  input  logic                          rsp_ready
);

  // data path
  logic                        misaligned;
  logic [axil_pkg::DATA_W-1:0] lane_data;
  logic [axil_pkg::STRB_W-1:0] strb;
  logic [axil_pkg::DATA_W-1:0] load_value;
  logic [1:0]                  offset;
  lsu_pkg::lsu_op_e            op_q;

  // AXI4-Lite between the FSM and the SRAM
  logic [axil_pkg::ADDR_W-1:0] araddr;
  logic                        arvalid;
  logic                        arready;
  logic [axil_pkg::DATA_W-1:0] rdata;
  axil_pkg::resp_e             rresp;
  logic                        rvalid;
  logic                        rready;
  logic [axil_pkg::ADDR_W-1:0] awaddr;
  logic                        awvalid;
  logic                        awready;
  logic [axil_pkg::DATA_W-1:0] wdata;
  logic [axil_pkg::STRB_W-1:0] wstrb;
  logic                        wvalid;
  logic                        wready;
  axil_pkg::resp_e             bresp;
  logic                        bvalid;
  logic                        bready;

  store_align u_store_align (
    .op         (req_op),
    .addr       (req_addr),
    .wdata      (req_wdata),
    .lane_data  (lane_data),
    .strb       (strb),
    .misaligned (misaligned)
  );

  // works on the offset and opcode captured at accept
  load_extract u_load_extract (
    .op     (op_q),
    .offset (offset),
    .rdata  (rdata),
    .value  (load_value)
  );

  lsu_fsm u_fsm (
    .clk        (clk),
    .rstn       (rstn),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_err    (rsp_err),
    .rsp_ready  (rsp_ready),
    .misaligned (misaligned),
    .lane_data  (lane_data),
    .strb       (strb),
    .load_value (load_value),
    .offset     (offset),
    .op_q       (op_q),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  axil_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_sram (
    .clk     (clk),
    .rstn    (rstn),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

  localparam int MEM_WORDS = 256;
  localparam int LIMIT     = 64;

  logic             clk;
  logic             rstn;
  logic             req_valid;
  lsu_pkg::lsu_op_e req_op;
  logic [31:0]      req_addr;
  logic [31:0]      req_wdata;
  logic             req_ready;
  logic             rsp_valid;
  logic [31:0]      rsp_rdata;
  logic             rsp_err;
  logic             rsp_ready;

  // expected response of the access in flight
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        exp_chk;
  logic        exp_misal;

  logic [7:0]  shadow [MEM_WORDS*4];
  integer      seed;
  int          n_acc;
  int          n_rsp;

  lsu_top uut (
    .clk       (clk),
    .rstn      (rstn),
    .req_valid (req_valid),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err),
    .rsp_ready (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    $display("=== FAIL ===");
    $fatal(1, "value check failed");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at t=%0t, %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "handshake timeout");
  endtask

  // little-endian view of the shadow bytes
  function automatic logic [31:0] load_expect(input lsu_pkg::lsu_op_e op,
                                              input logic [31:0] addr);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = shadow[addr];
    b1 = shadow[addr + 1];
    case (op)
      lsu_pkg::LB:  return {{24{b0[7]}}, b0};
      lsu_pkg::LBU: return {24'h0, b0};
      lsu_pkg::LH:  return {{16{b1[7]}}, b1, b0};
      lsu_pkg::LHU: return {16'h0, b1, b0};
      default:      return {shadow[addr + 3], shadow[addr + 2], b1, b0};
    endcase
  endfunction

  function automatic void shadow_store(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                                       input logic [31:0] data);
    shadow[addr] = data[7:0];
    if (op != lsu_pkg::SB) shadow[addr + 1] = data[15:8];
    if (op == lsu_pkg::SW) begin
      shadow[addr + 2] = data[23:16];
      shadow[addr + 3] = data[31:24];
    end
  endfunction

  // one request, then its response with rsp_ready held low for stall cycles
  task automatic access(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                        input logic [31:0] data, input int stall);
    logic misal;
    logic is_st;
    logic err;
    logic done;
    int   left;
    int   n;
    case (op)
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: misal = addr[0];
      lsu_pkg::LW, lsu_pkg::SW:               misal = |addr[1:0];
      default:                                misal = 1'b0;
    endcase
    is_st = (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
    err   = misal || (addr[31:2] >= MEM_WORDS);
    @(posedge clk);
    req_valid <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= data;
    rsp_ready <= (stall == 0);
    exp_misal <= misal;
    exp_err   <= err;
    exp_chk   <= !is_st && !err;
    exp_rdata <= (!is_st && !err) ? load_expect(op, addr) : 32'h0;
    n = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (req_ready) begin
        done = 1'b1;
      end else begin
        n++;
        if (n > LIMIT) report_timeout("req_ready never came back high");
      end
    end
    req_valid <= 1'b0;
    left = stall;
    n = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (rsp_valid && rsp_ready) begin
        done = 1'b1;
      end else begin
        if (rsp_valid) begin
          if (left <= 1) rsp_ready <= 1'b1;
          left--;
        end
        n++;
        if (n > LIMIT) report_timeout("rsp_valid handshake never completed");
      end
    end
    rsp_ready <= 1'b1;
    if (is_st && !err) shadow_store(op, addr, data);
  endtask

  always @(posedge clk) begin
    if (rstn) begin
      if (req_valid && req_ready) n_acc <= n_acc + 1;
      if (rsp_valid && rsp_ready) n_rsp <= n_rsp + 1;
    end
  end

  a_rsp_err: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid |-> rsp_err == exp_err)
    else report_mismatch("rsp_err", 32'($sampled(exp_err)), 32'($sampled(rsp_err)));

  // also catches data that moves while the core stalls
  a_rsp_data: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid && exp_chk |-> rsp_rdata == exp_rdata)
    else report_mismatch("rsp_rdata", $sampled(exp_rdata), $sampled(rsp_rdata));

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid && !rsp_ready |=> rsp_valid)
    else report_mismatch("rsp_valid", 32'd1, 32'($sampled(rsp_valid)));

  a_busy: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid |-> !req_ready)
    else report_mismatch("req_ready", 32'd0, 32'($sampled(req_ready)));

  // refused accesses answer in the very next cycle
  a_misal_turn: assert property (@(posedge clk) disable iff (!rstn)
    req_valid && req_ready && exp_misal |=> rsp_valid)
    else report_mismatch("rsp_valid", 32'd1, 32'($sampled(rsp_valid)));

  initial begin
    logic [31:0]      r;
    lsu_pkg::lsu_op_e op;
    seed      = 32'h0e71_7418;
    n_acc     = 0;
    n_rsp     = 0;
    rstn      = 1'b0;
    req_valid = 1'b0;
    req_op    = lsu_pkg::LB;
    req_addr  = 32'h0;
    req_wdata = 32'h0;
    rsp_ready = 1'b1;
    exp_rdata = 32'h0;
    exp_err   = 1'b0;
    exp_chk   = 1'b0;
    exp_misal = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;

    // word stores with read back fill the test region
    for (int w = 0; w < 16; w++) begin
      access(lsu_pkg::SW, w * 4, $random(seed), 0);
      access(lsu_pkg::LW, w * 4, 32'h0, 0);
    end

    // partial stores merge into the word
    for (int w = 0; w < 8; w++) begin
      for (int off = 0; off < 4; off++) begin
        access(lsu_pkg::SB, w * 4 + off, $random(seed), 0);
        access(lsu_pkg::LW, w * 4, 32'h0, 0);
        if (off[0] == 1'b0) begin
          access(lsu_pkg::SH, w * 4 + off, $random(seed), 0);
          access(lsu_pkg::LW, w * 4, 32'h0, 0);
        end
      end
    end

    // sign and zero extension
    for (int i = 0; i < 32; i++) begin
      r = $random(seed);
      op = lsu_pkg::lsu_op_e'({1'b0, r[1:0]});
      access(op, {r[7:4], r[10], (op >= lsu_pkg::LH) ? 1'b0 : r[9]} & 32'h3f, 32'h0, 0);
    end

    // misaligned halfwords and words
    for (int off = 1; off < 4; off++) begin
      if (off[0]) access(lsu_pkg::LH, 32'h10 + off, 32'h0, 0);
      if (off[0]) access(lsu_pkg::SH, 32'h10 + off, $random(seed), 0);
      access(lsu_pkg::LW, 32'h14 + off, 32'h0, 0);
      access(lsu_pkg::SW, 32'h14 + off, $random(seed), 0);
      access(lsu_pkg::LW, 32'h10, 32'h0, 0);
      access(lsu_pkg::LW, 32'h14, 32'h0, 0);
    end

    // beyond the SRAM
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      access(lsu_pkg::SW, {r[19:2], 2'b00} | (MEM_WORDS * 4), $random(seed), 0);
      access(lsu_pkg::LW, {r[19:2], 2'b00} | (MEM_WORDS * 4), 32'h0, 0);
      access(lsu_pkg::LBU, (MEM_WORDS * 4) + r[1:0], 32'h0, 0);
      access(lsu_pkg::LW, {r[5:2], 2'b00}, 32'h0, 0);
    end

    // random mix under response back-pressure
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      op = lsu_pkg::lsu_op_e'(r[2:0]);
      access(op, {26'h0, r[8:3]}, $random(seed), int'(r[12:10]));
    end

    repeat (3) @(posedge clk);
    assert (n_acc == n_rsp)
      else report_mismatch("response count", n_acc, n_rsp);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
verilog/lsu_pkg.sv
verilog/axil_pkg.sv
verilog/load_extract.sv
verilog/store_align.sv
verilog/lsu_fsm.sv
verilog/wait_timer.sv
verilog/axil_sram.sv
verilog/lsu_top.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_axil

sources:
  - verilog/lsu_pkg.sv
  - verilog/axil_pkg.sv
  - verilog/load_extract.sv
  - verilog/store_align.sv
  - verilog/lsu_fsm.sv
  - verilog/wait_timer.sv
  - verilog/axil_sram.sv
  - verilog/lsu_top.sv
  - target: simulation
    files:
      - verification/lsu_tb.sv
